// ==== Bender.yml ====
package:
  name: adc_capture

sources:
  - files:
      - hw/adc_pkg.sv
      - hw/adc_deserialise.sv
      - hw/adc_retime.sv
      - hw/adc_fcsample.sv
      - hw/adc_capture.sv
  - target: test
    files:
      - bench/adc_capture_tb.sv

// ==== bench/adc_capture_tb.sv ====
`default_nettype none

module adc_capture_tb;

  localparam int num_words     = 200;
  localparam int of_words      = 12;
  localparam int model_depth   = 256;
  localparam int timeout_limit = ((num_words + of_words) * adc_pkg::cycles_per_word + 200) * 4;

  logic             adc_clk0;
  logic             fab_clk;
  logic             reset;
  logic             in_rise [adc_pkg::num_lanes];
  logic             in_fall [adc_pkg::num_lanes];
  logic             fc_rise [adc_pkg::num_banks];
  logic             fc_fall [adc_pkg::num_banks];
  wire adc_pkg::sample_t adc_data [adc_pkg::num_lanes];
  wire logic        adc_dout_vld [adc_pkg::num_banks];
  wire logic        adc_fifo_of [adc_pkg::num_banks];
  wire adc_pkg::sample_t fc_sampled [adc_pkg::num_banks];

  adc_pkg::sample_t model_q [adc_pkg::num_lanes][model_depth];
  int               q_head [adc_pkg::num_lanes];
  int               q_tail [adc_pkg::num_lanes];
  int               run_cycles [adc_pkg::num_banks];  // cycles since the frame clock started
  int               cycle_cnt;
  int               errors;
  int unsigned      rnd;
  bit               pending;

  adc_capture dut (
    .adc_clk0     (adc_clk0),
    .fab_clk      (fab_clk),
    .reset        (reset),
    .in_rise      (in_rise),
    .in_fall      (in_fall),
    .fc_rise      (fc_rise),
    .fc_fall      (fc_fall),
    .adc_data     (adc_data),
    .adc_dout_vld (adc_dout_vld),
    .adc_fifo_of  (adc_fifo_of),
    .fc_sampled   (fc_sampled)
  );

  initial begin
    adc_clk0 = 1'b0;
    forever #10 adc_clk0 = ~adc_clk0;
  end

  initial begin
    fab_clk = 1'b0;
    forever #7 fab_clk = ~fab_clk;  // faster than the word rate
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checking helpers
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t %s: got %0h, expected %0h", $time, what, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    $display("%0t: %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // window seen after six steady cycles starting at word cycle phase
  function automatic adc_pkg::sample_t frame_window(input int phase);
    adc_pkg::sample_t win;
    int               cyc;
    logic             fc;
    win = '0;
    for (int i = 0; i < adc_pkg::cycles_per_word; i++) begin
      cyc = (phase + i) % adc_pkg::cycles_per_word;
      fc  = (cyc < adc_pkg::cycles_per_word / 2);
      win = {win[adc_pkg::sample_width-3:0], fc, fc};
    end
    return win;
  endfunction

  task automatic check_window(input int b);
    bit hit;
    hit = 1'b0;
    if (run_cycles[b] >= adc_pkg::cycles_per_word) begin
      for (int p = 0; p < adc_pkg::cycles_per_word; p++) begin
        if (fc_sampled[b] == frame_window(p)) hit = 1'b1;
      end
      check_eq(hit, 1, $sformatf("fc_sampled of bank %0d is no frame rotation", b));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // serialiser
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic idle_cycles(input int b, input int n, input bit lead_in);
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk0);
      #2;
      if (lead_in) check_eq(fc_sampled[b], 0, $sformatf("fc_sampled of bank %0d", b));
      for (int l = 0; l < adc_pkg::lanes_per_bank; l++) begin
        in_rise[b*adc_pkg::lanes_per_bank + l] = lead_in ? 1'($urandom) : 1'b0;
        in_fall[b*adc_pkg::lanes_per_bank + l] = lead_in ? 1'($urandom) : 1'b0;
      end
      fc_rise[b] = 1'b0;
      fc_fall[b] = 1'b0;
    end
    run_cycles[b] = 0;
  endtask

  task automatic send_words(input int b, input int n, input bit record);
    adc_pkg::sample_t word [adc_pkg::lanes_per_bank];
    int               lane;
    for (int w = 0; w < n; w++) begin
      for (int l = 0; l < adc_pkg::lanes_per_bank; l++) begin
        lane    = b*adc_pkg::lanes_per_bank + l;
        word[l] = adc_pkg::sample_t'($urandom);
        if (record) begin
          model_q[lane][q_tail[lane]] = word[l];
          q_tail[lane]++;
        end
      end
      for (int c = 0; c < adc_pkg::cycles_per_word; c++) begin
        @(posedge adc_clk0);
        #2;
        check_window(b);
        for (int l = 0; l < adc_pkg::lanes_per_bank; l++) begin
          lane          = b*adc_pkg::lanes_per_bank + l;
          in_rise[lane] = word[l][adc_pkg::sample_width-1-2*c];  // msb first, rise leads
          in_fall[lane] = word[l][adc_pkg::sample_width-2-2*c];
        end
        fc_rise[b] = (c < adc_pkg::cycles_per_word / 2);
        fc_fall[b] = (c < adc_pkg::cycles_per_word / 2);
        run_cycles[b]++;
      end
    end
  endtask

  // one more boundary so the last word gets emitted, then the frame clock stops
  task automatic close_frame(input int b);
    @(posedge adc_clk0);
    #2;
    check_window(b);
    for (int l = 0; l < adc_pkg::lanes_per_bank; l++) begin
      in_rise[b*adc_pkg::lanes_per_bank + l] = 1'($urandom);
      in_fall[b*adc_pkg::lanes_per_bank + l] = 1'($urandom);
    end
    fc_rise[b] = 1'b1;
    fc_fall[b] = 1'b1;
    idle_cycles(b, 1, 1'b0);
  endtask

  task automatic run_bank(input int b);
    idle_cycles(b, $urandom % adc_pkg::cycles_per_word, 1'b1);  // random start phase
    send_words(b, num_words, 1'b1);
    close_frame(b);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // monitor and timeout
  // ~~~~~~~~~~~~~~~~~~~~

  always @(negedge fab_clk) begin
    if (!reset) begin
      for (int b = 1; b < adc_pkg::num_banks; b++) begin
        check_eq(adc_dout_vld[b], adc_dout_vld[0], $sformatf("dout_vld of bank %0d", b));
      end
      if (adc_dout_vld[0]) begin
        for (int l = 0; l < adc_pkg::num_lanes; l++) begin
          if (q_head[l] == q_tail[l]) begin
            report_failure($sformatf("lane %0d delivered a sample nobody sent", l));
          end
          check_eq(adc_data[l], model_q[l][q_head[l]], $sformatf("adc_data lane %0d", l));
          q_head[l]++;
        end
      end
    end
  end

  always @(posedge adc_clk0) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      report_failure($sformatf("timeout, run still busy after %0d cycles", timeout_limit));
    end
  end

  initial begin
    rnd       = $urandom(32'h0c919e83);
    reset     = 1'b1;
    cycle_cnt = 0;
    errors    = 0;
    for (int l = 0; l < adc_pkg::num_lanes; l++) begin
      in_rise[l] = 1'b0;
      in_fall[l] = 1'b0;
      q_head[l]  = 0;
      q_tail[l]  = 0;
    end
    for (int b = 0; b < adc_pkg::num_banks; b++) begin
      fc_rise[b]    = 1'b0;
      fc_fall[b]    = 1'b0;
      run_cycles[b] = 0;
    end
    repeat (5) @(posedge adc_clk0);
    #2;
    reset = 1'b0;
    for (int b = 0; b < adc_pkg::num_banks; b++) begin
      check_eq(adc_dout_vld[b], 0, $sformatf("dout_vld of bank %0d after reset", b));
      check_eq(adc_fifo_of[b], 0, $sformatf("fifo_of of bank %0d after reset", b));
      check_eq(fc_sampled[b], 0, $sformatf("fc_sampled of bank %0d after reset", b));
    end

    fork
      run_bank(0);
      run_bank(1);
    join

    pending = 1'b1;
    while (pending) begin
      @(posedge adc_clk0);
      pending = 1'b0;
      for (int l = 0; l < adc_pkg::num_lanes; l++) begin
        if (q_head[l] != q_tail[l]) pending = 1'b1;
      end
    end
    repeat (10) @(posedge adc_clk0);  // let the pointer synchronisers settle

    // bank 1 stays silent, so nothing is read and bank 0 fills up
    send_words(0, 8, 1'b0);
    close_frame(0);  // the closing boundary writes the eighth word
    check_eq(adc_fifo_of[0], 0, "fifo_of of bank 0 after 8 words");
    send_words(0, of_words - 8, 1'b0);
    close_frame(0);
    repeat (3) @(posedge adc_clk0);
    #2;
    check_eq(adc_fifo_of[0], 1, "fifo_of of bank 0 after 12 words");
    check_eq(adc_fifo_of[1], 0, "fifo_of of bank 1 while idle");

    reset = 1'b1;
    repeat (5) @(posedge adc_clk0);
    #2;
    reset = 1'b0;
    for (int b = 0; b < adc_pkg::num_banks; b++) begin
      check_eq(adc_fifo_of[b], 0, $sformatf("fifo_of of bank %0d after second reset", b));
    end

    if (errors == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "errors were found");
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
hw/adc_pkg.sv
hw/adc_deserialise.sv
hw/adc_retime.sv
hw/adc_fcsample.sv
hw/adc_capture.sv
bench/adc_capture_tb.sv

// ==== hw/adc_capture.sv ====
`default_nettype none

module adc_capture (
  input  wire logic             adc_clk0,
  input  wire logic             fab_clk,
  input  wire logic             reset,
  input  wire logic             in_rise [adc_pkg::num_lanes],
  input  wire logic             in_fall [adc_pkg::num_lanes],
  input  wire logic             fc_rise [adc_pkg::num_banks],
  input  wire logic             fc_fall [adc_pkg::num_banks],
  output wire adc_pkg::sample_t adc_data [adc_pkg::num_lanes],
  output wire logic             adc_dout_vld [adc_pkg::num_banks],
  output wire logic             adc_fifo_of [adc_pkg::num_banks],
  output wire adc_pkg::sample_t fc_sampled [adc_pkg::num_banks]
);

  wire [adc_pkg::num_banks-1:0] fifo_empty;
  wire                          rd_en;

  assign rd_en = ~|fifo_empty;  // pop every bank in the same cycle to keep them aligned

  for (genvar b = 0; b < adc_pkg::num_banks; b++) begin : g_bank
    logic             bank_rise [adc_pkg::lanes_per_bank];
    logic             bank_fall [adc_pkg::lanes_per_bank];
    adc_pkg::sample_t bank_pout [adc_pkg::lanes_per_bank];
    adc_pkg::sample_t bank_dout [adc_pkg::lanes_per_bank];
    logic             bank_pvld;

    // ~~~~~~~~~~~~~~~~~~~~
    // lane mapping
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar l = 0; l < adc_pkg::lanes_per_bank; l++) begin : g_lane
      assign bank_rise[l] = in_rise[b*adc_pkg::lanes_per_bank + l];
      assign bank_fall[l] = in_fall[b*adc_pkg::lanes_per_bank + l];
      assign adc_data[b*adc_pkg::lanes_per_bank + l] = bank_dout[l];
    end

    adc_deserialise u_deserialise (
      .adc_clk0    (adc_clk0),
      .reset       (reset),
      .serial_rise (bank_rise),
      .serial_fall (bank_fall),
      .fclk_rise   (fc_rise[b]),
      .fclk_fall   (fc_fall[b]),
      .pout        (bank_pout),
      .pvld        (bank_pvld)
    );

    adc_retime u_retime (
      .adc_clk0   (adc_clk0),
      .fab_clk    (fab_clk),
      .reset      (reset),
      .din        (bank_pout),
      .dvld       (bank_pvld),
      .rd_en      (rd_en),
      .dout       (bank_dout),
      .dout_vld   (adc_dout_vld[b]),
      .fifo_empty (fifo_empty[b]),
      .fifo_of    (adc_fifo_of[b])
    );

    adc_fcsample u_fcsample (
      .adc_clk0   (adc_clk0),
      .reset      (reset),
      .fc_rise    (fc_rise[b]),
      .fc_fall    (fc_fall[b]),
      .fc_sampled (fc_sampled[b])
    );
  end

endmodule

`default_nettype wire

// ==== hw/adc_deserialise.sv ====
`default_nettype none

module adc_deserialise (
  input  wire logic       adc_clk0,
  input  wire logic       reset,
  input  wire logic       serial_rise [adc_pkg::lanes_per_bank],
  input  wire logic       serial_fall [adc_pkg::lanes_per_bank],
  input  wire logic       fclk_rise,
  input  wire logic       fclk_fall,
  output adc_pkg::sample_t pout [adc_pkg::lanes_per_bank],
  output logic            pvld
);

  adc_pkg::deser_state_e state;
  adc_pkg::sample_t      shift [adc_pkg::lanes_per_bank];
  logic [2:0]            pair_cnt;
  logic                  fclk_fall_q;
  logic                  boundary;
  logic                  word_done;
  logic                  emit;

  assign boundary  = fclk_rise && !fclk_fall_q;  // frame clock went high between cycles
  assign word_done = (pair_cnt == 3'(adc_pkg::cycles_per_word));
  assign emit      = boundary && word_done && (state == adc_pkg::st_lock);

  // ~~~~~~~~~~~~~~~~~~~~
  // frame tracking
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge adc_clk0) begin
    if (reset) begin
      state       <= adc_pkg::st_hunt;
      pair_cnt    <= '0;
      fclk_fall_q <= 1'b0;
      pvld        <= 1'b0;
    end else begin
      fclk_fall_q <= fclk_fall;
      pvld        <= emit;
      if (boundary) begin
        state    <= adc_pkg::st_lock;
        pair_cnt <= 3'd1;  // bits 11 and 10 come in with the boundary
      end else if (pair_cnt != 3'd7) begin
        pair_cnt <= pair_cnt + 3'd1;  // sticks at 7 so a late boundary is not a word
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // sample shifters
  // ~~~~~~~~~~~~~~~~~~~~

  // Six shifts flush a register completely, so a restarted word needs no clear.
  always_ff @(posedge adc_clk0) begin
    for (int l = 0; l < adc_pkg::lanes_per_bank; l++) begin
      shift[l] <= {shift[l][adc_pkg::sample_width-adc_pkg::bits_per_cycle-1:0],
                   serial_rise[l], serial_fall[l]};  // rise bit is the more significant
      if (emit) begin
        pout[l] <= shift[l];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/adc_fcsample.sv ====
`default_nettype none

module adc_fcsample (
  input  wire logic       adc_clk0,
  input  wire logic       reset,
  input  wire logic       fc_rise,
  input  wire logic       fc_fall,
  output adc_pkg::sample_t fc_sampled
);

  // Software reads this window to see where the frame edge sits while it
  // steps the input delays. A locked frame gives one of the six rotations
  // of 111111000000.

  always_ff @(posedge adc_clk0) begin
    if (reset) begin
      fc_sampled <= '0;
    end else begin
      fc_sampled <= {fc_sampled[adc_pkg::sample_width-adc_pkg::bits_per_cycle-1:0],
                     fc_rise, fc_fall};  // oldest sample drops out of bit 11
    end
  end

endmodule

`default_nettype wire

// ==== hw/adc_pkg.sv ====
`default_nettype none

package adc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // sample framing
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int sample_width    = 12;
  localparam int bits_per_cycle  = 2;  // one bit on each edge of the bit clock
  localparam int cycles_per_word = sample_width / bits_per_cycle;

  // ~~~~~~~~~~~~~~~~~~~~
  // array geometry
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int num_banks       = 2;
  localparam int lanes_per_bank  = 4;
  localparam int num_lanes       = num_banks * lanes_per_bank;

  localparam int fifo_depth_log2 = 3;  // eight bank-wide entries per retime FIFO

  typedef logic [sample_width-1:0] sample_t;

  typedef enum logic {
    st_hunt,  // no frame edge seen yet
    st_lock   // word boundaries follow the frame clock
  } deser_state_e;

endpackage

`default_nettype wire

// ==== hw/adc_retime.sv ====
`default_nettype none

module adc_retime (
  input  wire logic             adc_clk0,
  input  wire logic             fab_clk,
  input  wire logic             reset,
  input  wire adc_pkg::sample_t din [adc_pkg::lanes_per_bank],
  input  wire logic             dvld,
  input  wire logic             rd_en,
  output adc_pkg::sample_t      dout [adc_pkg::lanes_per_bank],
  output logic                  dout_vld,
  output logic                  fifo_empty,
  output logic                  fifo_of
);

  adc_pkg::sample_t mem [2**adc_pkg::fifo_depth_log2][adc_pkg::lanes_per_bank];

  logic [adc_pkg::fifo_depth_log2:0] wr_bin;
  logic [adc_pkg::fifo_depth_log2:0] wr_bin_inc;
  logic [adc_pkg::fifo_depth_log2:0] wr_gray;
  logic [adc_pkg::fifo_depth_log2:0] rd_gray_w1;
  logic [adc_pkg::fifo_depth_log2:0] rd_gray_w2;
  logic [adc_pkg::fifo_depth_log2:0] rd_bin;
  logic [adc_pkg::fifo_depth_log2:0] rd_bin_inc;
  logic [adc_pkg::fifo_depth_log2:0] rd_gray;
  logic [adc_pkg::fifo_depth_log2:0] wr_gray_r1;
  logic [adc_pkg::fifo_depth_log2:0] wr_gray_r2;
  logic                              fifo_full;
  logic                              wr_fire;
  logic                              rd_fire;

  // ~~~~~~~~~~~~~~~~~~~~
  // write side, adc_clk0
  // ~~~~~~~~~~~~~~~~~~~~

  assign wr_bin_inc = wr_bin + 1'b1;
  // full when the pointers differ only in the two top Gray bits
  assign fifo_full  = (wr_gray == (rd_gray_w2 ^
                       {2'b11, {(adc_pkg::fifo_depth_log2-1){1'b0}}}));
  assign wr_fire    = dvld && !fifo_full;

  always_ff @(posedge adc_clk0) begin
    if (reset) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
      fifo_of    <= 1'b0;
    end else begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      if (wr_fire) begin
        wr_bin  <= wr_bin_inc;
        wr_gray <= wr_bin_inc ^ (wr_bin_inc >> 1);
      end
      if (dvld && fifo_full) begin
        fifo_of <= 1'b1;  // the word is lost, flag stays up until reset
      end
    end
  end

  always_ff @(posedge adc_clk0) begin
    if (wr_fire) begin
      mem[wr_bin[adc_pkg::fifo_depth_log2-1:0]] <= din;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // read side, fab_clk
  // ~~~~~~~~~~~~~~~~~~~~

  assign rd_bin_inc = rd_bin + 1'b1;
  assign fifo_empty = (rd_gray == wr_gray_r2);
  assign rd_fire    = rd_en && !fifo_empty;

  always_ff @(posedge fab_clk) begin
    if (reset) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
      dout_vld   <= 1'b0;
    end else begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      dout_vld   <= rd_fire;
      if (rd_fire) begin
        rd_bin  <= rd_bin_inc;
        rd_gray <= rd_bin_inc ^ (rd_bin_inc >> 1);
      end
    end
  end

  always_ff @(posedge fab_clk) begin
    if (rd_fire) begin
      dout <= mem[rd_bin[adc_pkg::fifo_depth_log2-1:0]];  // lines up with dout_vld
    end
  end

endmodule

`default_nettype wire
